// File: bench/conv_clock.sv
`timescale 1ns/1ps
`default_nettype none

module conv_clock (
  output logic clk
);

  localparam int HALF_PERIOD = 50;  // 100 ns period

  initial begin
    clk = 1'b0;
    forever begin
      #HALF_PERIOD clk = ~clk;
    end
  end

endmodule

`default_nettype wire

// File: bench/conv_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_consts.svh"

module conv_tb;

  import conv_pkg::*;

  localparam int FRAMES         = 4;
  localparam int FRAME_PIX      = `IMG_W * `IMG_H;
  localparam int OUT_W          = `IMG_W - `CONV_K + 1;
  localparam int OUT_H          = `IMG_H - `CONV_K + 1;
  localparam int RESULTS        = OUT_W * OUT_H;
  localparam int TIMEOUT_CYCLES = FRAMES * FRAME_PIX * 4 + 2000;

  logic        clk;
  logic        rst_n;
  logic        in_valid;
  logic        in_ready;
  pixel_t      in_data;
  logic        kernel_valid;
  kernel_cmd_t kernel_cmd;
  logic        out_valid;
  logic        out_ready;
  result_t     out_data;

  logic [`COEF_W-1:0] coef_model [`CONV_TAPS];
  logic [`PIX_W-1:0]  frame_pix  [FRAME_PIX];
  result_t            exp_q [$];  // Expected results in raster order of window position
  result_t            exp_res;
  result_t            held_res;
  bit                 held_pending;
  int                 results_seen;
  int                 frame_start;
  int                 cycle_cnt;
  int                 value_errors;
  int                 hold_errors;
  int                 protocol_errors;
  int                 timeout_errors;

  conv_clock u_conv_clock (
    .clk (clk)
  );

  conv_top u_conv_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .in_data      (in_data),
    .kernel_valid (kernel_valid),
    .kernel_cmd   (kernel_cmd),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_data     (out_data)
  );

  task automatic check_sum(input result_t exp, input result_t act);
    if (act.sum !== exp.sum) begin
      $display("[FAIL] out_data.sum expected %h actual %h", exp.sum, act.sum);
      value_errors++;
    end
  endtask

  task automatic check_last(input result_t exp, input result_t act);
    if (act.last !== exp.last) begin
      $display("[FAIL] out_data.last expected %h actual %h", exp.last, act.last);
      value_errors++;
    end
  endtask

  task automatic check_hold(input result_t exp, input result_t act);
    if (act !== exp) begin
      $display("[FAIL] out_data held expected %h actual %h", exp, act);
      hold_errors++;
    end
  endtask

  task automatic finish_run();
    $display("Errors: value %0d, hold %0d, protocol %0d, timeout %0d",
             value_errors, hold_errors, protocol_errors, timeout_errors);
    if (value_errors + hold_errors + protocol_errors + timeout_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  endtask

  // One command per falling edge, mirrored into the coefficient model
  task automatic send_cmd(input coef_op_t op, input logic [4:0] index,
                          input logic [`COEF_W-1:0] value);
    @(negedge clk);
    kernel_valid     = 1'b1;
    kernel_cmd.op    = op;
    kernel_cmd.index = index;
    kernel_cmd.value = value;
    if (op == OP_CLEAR) begin
      for (int t = 0; t < `CONV_TAPS; t++) begin
        coef_model[t] = '0;
      end
    end else if (int'(index) < `CONV_TAPS) begin
      coef_model[index] = value;
    end
  endtask

  task automatic load_kernel(input int frame_no);
    send_cmd(OP_CLEAR, 5'd0, '0);
    if (frame_no == 2) begin
      for (int t = 0; t < `CONV_TAPS; t++) begin
        send_cmd(OP_WRITE, 5'(t), '1);                 // Largest kernel
      end
    end else if (frame_no != 0) begin
      for (int n = 0; n < 40; n++) begin
        send_cmd(OP_WRITE, 5'($urandom % `CONV_TAPS), `COEF_W'($urandom));
      end
    end
    // Writes past the last tap must not touch the kernel
    if (frame_no >= 2) begin
      for (int n = 0; n < 4; n++) begin
        send_cmd(OP_WRITE, 5'(`CONV_TAPS + ($urandom % 7)), `COEF_W'($urandom));
      end
    end
    @(negedge clk);
    kernel_valid = 1'b0;
    kernel_cmd   = '0;
  endtask

  function automatic void fill_frame(input int frame_no);
    for (int p = 0; p < FRAME_PIX; p++) begin
      if (frame_no == 2) begin
        frame_pix[p] = '1;
      end else begin
        frame_pix[p] = `PIX_W'($urandom);
      end
    end
  endfunction

  // Valid convolution, one result per window fully inside the frame
  function automatic void build_expected();
    result_t r;
    int      acc;
    for (int row = 0; row < OUT_H; row++) begin
      for (int col = 0; col < OUT_W; col++) begin
        acc = 0;
        for (int i = 0; i < `CONV_K; i++) begin
          for (int j = 0; j < `CONV_K; j++) begin
            acc += int'(frame_pix[(row + i) * `IMG_W + col + j])
                 * int'(coef_model[i * `CONV_K + j]);
          end
        end
        r.sum  = `SUM_W'(acc);
        r.last = (row == OUT_H - 1) && (col == OUT_W - 1);
        exp_q.push_back(r);
      end
    end
  endfunction

  // An aborted frame of fewer than four rows goes ahead when prefix is nonzero
  task automatic stream_frame(input int prefix);
    int idx;
    idx         = 0;
    frame_start = results_seen;
    while (idx < prefix + FRAME_PIX) begin
      @(negedge clk);
      if (($urandom % 4) == 0) begin
        in_valid = 1'b0;                                 // Gap in the pixel stream
      end else if (idx < prefix) begin
        in_valid     = 1'b1;
        in_data.data = `PIX_W'($urandom);
        in_data.sof  = (idx == 0);
      end else begin
        in_valid     = 1'b1;
        in_data.data = frame_pix[idx - prefix];
        in_data.sof  = (idx == prefix);                  // Restarts the frame origin
      end
      @(posedge clk);
      if (in_valid && in_ready) begin
        idx++;
      end
    end
    @(negedge clk);
    in_valid = 1'b0;
    in_data  = '0;
  endtask

  task automatic drain_frame(input int frame_no);
    int produced;
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (10) @(posedge clk);
    produced = results_seen - frame_start;
    if (produced != RESULTS) begin
      $display("Frame %0d produced %0d results instead of %0d", frame_no, produced, RESULTS);
      protocol_errors++;
    end
  endtask

  always @(negedge clk) begin
    out_ready = ($urandom % 100) < 70;
  end

  // Output monitor with the stall hold check
  always @(posedge clk) begin
    if (!rst_n) begin
      held_pending = 1'b0;
    end else begin
      if (held_pending) begin
        if (!out_valid) begin
          $display("out_valid dropped while a result was waiting for out_ready");
          hold_errors++;
        end else begin
          check_hold(held_res, out_data);
        end
      end
      if (out_valid && out_ready) begin
        results_seen++;
        if (exp_q.size() == 0) begin
          $display("Unexpected result %h arrived with none expected", out_data.sum);
          protocol_errors++;
        end else begin
          exp_res = exp_q.pop_front();
          check_sum(exp_res, out_data);
          check_last(exp_res, out_data);
        end
      end
      held_pending = out_valid && !out_ready;
      held_res     = out_data;
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Run stopped after %0d cycles with %0d results still expected",
               cycle_cnt, exp_q.size());
      timeout_errors++;
      finish_run();
    end
  end

  initial begin
    void'($urandom(32'hd088));
    rst_n        = 1'b0;
    in_valid     = 1'b0;
    in_data      = '0;
    kernel_valid = 1'b0;
    kernel_cmd   = '0;
    out_ready    = 1'b0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    for (int f = 0; f < FRAMES; f++) begin
      load_kernel(f);                                    // Pipeline is empty here
      fill_frame(f);
      build_expected();
      stream_frame((f % 2 == 1) ? 16 + int'($urandom % 48) : 0);
      drain_frame(f);
    end
    finish_run();
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+logic
logic/conv_pkg.sv
logic/conv_window.sv
logic/conv_kernel_bank.sv
logic/conv_mult_stage.sv
logic/conv_adder_tree.sv
logic/conv_top.sv
bench/conv_clock.sv
bench/conv_tb.sv

// File: logic/conv_adder_tree.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_consts.svh"

module conv_adder_tree (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                advance,
  input  wire logic                prod_valid,
  input  wire conv_pkg::prod_vec_t prods,
  input  wire logic                prod_last,
  output      logic                res_valid,
  output      conv_pkg::result_t   res
);

  // Five products need three extra bits
  localparam int ROW_SUM_W = `PROD_W + 3;

  logic [ROW_SUM_W-1:0] row_acc [`CONV_K];
  logic [ROW_SUM_W-1:0] row_sum [`CONV_K];
  logic                 l1_valid;
  logic                 l1_last;
  logic [`SUM_W-1:0]    total;

  // Level 1 adds up one window row each
  always_comb begin
    for (int i = 0; i < `CONV_K; i++) begin
      row_acc[i] = '0;
      for (int j = 0; j < `CONV_K; j++) begin
        row_acc[i] = row_acc[i] + ROW_SUM_W'(prods[i*`CONV_K + j]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      for (int i = 0; i < `CONV_K; i++) begin
        row_sum[i] <= row_acc[i];
      end
    end
  end

  // Level 2 folds the row sums into the final width
  always_comb begin
    total = '0;
    for (int i = 0; i < `CONV_K; i++) begin
      total = total + `SUM_W'(row_sum[i]);
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      res.sum  <= total;
      res.last <= l1_last;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      l1_valid  <= 1'b0;
      l1_last   <= 1'b0;
      res_valid <= 1'b0;
    end else if (advance) begin
      l1_valid  <= prod_valid;
      l1_last   <= prod_valid && prod_last;
      res_valid <= l1_valid;
    end
  end

endmodule

`default_nettype wire

// File: logic/conv_consts.svh
`ifndef CONV_CONSTS_SVH
`define CONV_CONSTS_SVH

// Kernel geometry
`define CONV_K    5
`define CONV_TAPS 25

// Data widths
`define PIX_W     6
`define COEF_W    6
`define PROD_W    12
`define SUM_W     18

// Frame geometry in pixels and rows
`define IMG_W     16
`define IMG_H     8
`define COL_W     4
`define ROW_W     3

`endif

// File: logic/conv_kernel_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_consts.svh"

module conv_kernel_bank (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  kernel_valid,
  input  wire conv_pkg::kernel_cmd_t kernel_cmd,
  output      conv_pkg::kernel_t     kernel
);

  import conv_pkg::*;

  logic index_ok;

  assign index_ok = kernel_cmd.index < 5'(`CONV_TAPS);  // Writes past tap 24 are dropped

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      kernel <= '0;
    end else if (kernel_valid) begin
      case (kernel_cmd.op)
        OP_WRITE: begin
          if (index_ok) begin
            kernel[kernel_cmd.index] <= kernel_cmd.value;
          end
        end
        OP_CLEAR: begin
          kernel <= '0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/conv_mult_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_consts.svh"

module conv_mult_stage (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                advance,
  input  wire logic                win_valid,
  input  wire conv_pkg::window_t   win,
  input  wire logic                win_last,
  input  wire conv_pkg::kernel_t   kernel,
  output      logic                prod_valid,
  output      conv_pkg::prod_vec_t prods,
  output      logic                prod_last
);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      prod_valid <= 1'b0;
      prod_last  <= 1'b0;
    end else if (advance) begin
      prod_valid <= win_valid;
      prod_last  <= win_valid && win_last;
    end
  end

  // Unsigned 6x6 products, one per tap
  always_ff @(posedge clk) begin
    if (advance) begin
      for (int t = 0; t < `CONV_TAPS; t++) begin
        prods[t] <= `PROD_W'(win[t]) * `PROD_W'(kernel[t]);
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/conv_pkg.sv
`default_nettype none

`include "conv_consts.svh"

package conv_pkg;

  // Input stream word
  typedef struct packed {
    logic [`PIX_W-1:0] data;
    logic              sof;   // First pixel of a frame
  } pixel_t;

  typedef enum logic [0:0] {
    OP_WRITE = 1'b0,          // Set one coefficient
    OP_CLEAR = 1'b1           // Zero the whole kernel
  } coef_op_t;

  typedef struct packed {
    coef_op_t           op;
    logic [4:0]         index;
    logic [`COEF_W-1:0] value;
  } kernel_cmd_t;

  // Tap i*5+j is window row i, column j, row 0 and column 0 the oldest
  typedef logic [`CONV_TAPS-1:0][`PIX_W-1:0]  window_t;
  typedef logic [`CONV_TAPS-1:0][`COEF_W-1:0] kernel_t;
  typedef logic [`CONV_TAPS-1:0][`PROD_W-1:0] prod_vec_t;

  // Output stream word
  typedef struct packed {
    logic [`SUM_W-1:0] sum;
    logic              last;  // Final window of the frame
  } result_t;

endpackage

`default_nettype wire

// File: logic/conv_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_consts.svh"

module conv_top (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  in_valid,
  output      logic                  in_ready,
  input  wire conv_pkg::pixel_t      in_data,
  input  wire logic                  kernel_valid,
  input  wire conv_pkg::kernel_cmd_t kernel_cmd,
  output      logic                  out_valid,
  input  wire logic                  out_ready,
  output      conv_pkg::result_t     out_data
);

  import conv_pkg::*;

  logic      advance;
  logic      win_valid;
  window_t   win;
  logic      win_last;
  kernel_t   kernel;
  logic      prod_valid;
  prod_vec_t prods;
  logic      prod_last;
  logic      res_valid;
  result_t   res;

  // One enable for every stage, so a stall freezes the whole pipeline
  assign advance  = !out_valid || out_ready;
  assign in_ready = advance;

  assign out_valid = res_valid;
  assign out_data  = res;

  conv_window u_conv_window (
    .clk       (clk),
    .rst_n     (rst_n),
    .advance   (advance),
    .pix_valid (in_valid),
    .pix       (in_data),
    .win_valid (win_valid),
    .win       (win),
    .win_last  (win_last)
  );

  conv_kernel_bank u_conv_kernel_bank (
    .clk          (clk),
    .rst_n        (rst_n),
    .kernel_valid (kernel_valid),
    .kernel_cmd   (kernel_cmd),
    .kernel       (kernel)
  );

  conv_mult_stage u_conv_mult_stage (
    .clk        (clk),
    .rst_n      (rst_n),
    .advance    (advance),
    .win_valid  (win_valid),
    .win        (win),
    .win_last   (win_last),
    .kernel     (kernel),
    .prod_valid (prod_valid),
    .prods      (prods),
    .prod_last  (prod_last)
  );

  conv_adder_tree u_conv_adder_tree (
    .clk        (clk),
    .rst_n      (rst_n),
    .advance    (advance),
    .prod_valid (prod_valid),
    .prods      (prods),
    .prod_last  (prod_last),
    .res_valid  (res_valid),
    .res        (res)
  );

endmodule

`default_nettype wire

// File: logic/conv_window.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_consts.svh"

module conv_window (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              advance,
  input  wire logic              pix_valid,
  input  wire conv_pkg::pixel_t  pix,
  output      logic              win_valid,
  output      conv_pkg::window_t win,
  output      logic              win_last
);

  // Buffer 0 holds the previous row, buffer 3 the row four above
  logic [`PIX_W-1:0] line_buf [`CONV_K-1][`IMG_W];

  logic [`COL_W-1:0] col_cnt;
  logic [`ROW_W-1:0] row_cnt;
  logic [`COL_W-1:0] cur_col;
  logic [`ROW_W-1:0] cur_row;
  logic              accept;
  logic              win_full;
  logic [`PIX_W-1:0] new_col [`CONV_K];

  assign accept  = pix_valid && advance;
  assign cur_col = pix.sof ? '0 : col_cnt;  // sof pins this pixel to the frame origin
  assign cur_row = pix.sof ? '0 : row_cnt;

  assign win_full = (cur_row >= `ROW_W'(`CONV_K - 1)) && (cur_col >= `COL_W'(`CONV_K - 1));

  // Column entering the window, oldest row on top
  always_comb begin
    for (int i = 0; i < `CONV_K - 1; i++) begin
      new_col[i] = line_buf[`CONV_K - 2 - i][cur_col];
    end
    new_col[`CONV_K-1] = pix.data;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_cnt <= '0;
      row_cnt <= '0;
    end else if (accept) begin
      if (cur_col == `COL_W'(`IMG_W - 1)) begin
        col_cnt <= '0;
        if (cur_row == `ROW_W'(`IMG_H - 1)) begin
          row_cnt <= '0;                           // Frame done, next pixel carries sof
        end else begin
          row_cnt <= cur_row + 1'b1;
        end
      end else begin
        col_cnt <= cur_col + 1'b1;
        row_cnt <= cur_row;
      end
    end
  end

  // Line buffers shift one row down per column position
  always_ff @(posedge clk) begin
    if (accept) begin
      for (int k = `CONV_K - 2; k > 0; k--) begin
        line_buf[k][cur_col] <= line_buf[k-1][cur_col];
      end
      line_buf[0][cur_col] <= pix.data;
    end
  end

  // Sliding window moves one column left per accepted pixel
  always_ff @(posedge clk) begin
    if (accept) begin
      for (int i = 0; i < `CONV_K; i++) begin
        for (int j = 0; j < `CONV_K - 1; j++) begin
          win[i*`CONV_K + j] <= win[i*`CONV_K + j + 1];
        end
        win[i*`CONV_K + `CONV_K - 1] <= new_col[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      win_valid <= 1'b0;
      win_last  <= 1'b0;
    end else if (advance) begin
      win_valid <= accept && win_full;
      win_last  <= accept && (cur_row == `ROW_W'(`IMG_H - 1))
                          && (cur_col == `COL_W'(`IMG_W - 1));
    end
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Compile the convolution engine with its testbench and run it under Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
  --timescale 1ns/1ps \
  -f build.f \
  --top-module conv_tb \
  -Mdir obj_dir \
  -o conv_tb_sim

./obj_dir/conv_tb_sim > sim.log 2>&1
cat sim.log

# The run counts as passed only when the log holds the pass line
grep -q "Testbench passed" sim.log
